// File: source/sparc_pkg.sv
package sparc_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// IR[31:30]
	typedef enum logic [1:0] {
		fam_branch = 2'b00,
		fam_call   = 2'b01,
		fam_arith  = 2'b10,
		fam_mem    = 2'b11
	} op_family_e;

	// op3 for the arith family
	typedef enum logic [5:0] {
		alu_add   = 6'b000000,
		alu_and   = 6'b000001,
		alu_or    = 6'b000010,
		alu_xor   = 6'b000011,
		alu_sub   = 6'b000100,
		alu_addcc = 6'b010000, // Bit 4 marks the cc forms
		alu_andcc = 6'b010001,
		alu_subcc = 6'b010100,
		alu_jmpl  = 6'b111000
	} alu_op_e;

	// op3 for the memory family
	typedef enum logic [5:0] {
		mem_ld   = 6'b000000,
		mem_ldub = 6'b000001,
		mem_st   = 6'b000100,
		mem_stb  = 6'b000101
	} mem_op_e;

	// Bicc cond field IR[28:25]
	typedef enum logic [3:0] {
		cond_bn  = 4'b0000,
		cond_be  = 4'b0001,
		cond_bl  = 4'b0011,
		cond_ba  = 4'b1000,
		cond_bne = 4'b1001,
		cond_bge = 4'b1011
	} cond_e;

	localparam logic [2:0] bicc_op2 = 3'b010; // IR[24:22] of a Bicc

	typedef enum logic [3:0] {
		s_idle, s_decode, s_alu_exec, s_alu_wb, s_br_exec, s_jmpl_link, s_jmpl_target,
		s_mem_addr, s_mem_mar, s_ld_wait, s_ld_mdr, s_ld_wb, s_st_mdr, s_st_wait
	} cu_state_e;

	typedef enum logic [1:0] {alub_regb, alub_ext, alub_mdr, alub_pc} alub_sel_e;
	typedef enum logic {ext_simm13, ext_disp22} ext_sel_e;
	typedef enum logic [1:0] {pc_in_seq, pc_in_target, pc_in_alu} pc_in_sel_e;

	typedef struct packed {
		logic n; // Negative
		logic z; // Zero
		logic v; // Overflow
		logic c; // Carry, borrow on sub
	} icc_t;

endpackage

// File: source/ctrl_if.sv
`timescale 1ns/100ps

interface ctrl_if;
	// Register load strobes, one cycle each
	logic ir_en;
	logic pc_en;
	logic npc_en;
	logic mar_en;
	logic mdr_en;
	logic rf_we;
	logic psr_en;
	// Mux selects
	sparc_pkg::alub_sel_e  alub_sel;
	sparc_pkg::ext_sel_e   ext_sel;
	sparc_pkg::pc_in_sel_e pc_in_sel;
	logic                  mdr_sel; // 1 = RAM data, 0 = register B
	// Register file addresses
	sparc_pkg::reg_addr_t ra, rb, rd;
	sparc_pkg::alu_op_e   alu_op;
	// Status back to the FSM
	sparc_pkg::word_t ir;
	sparc_pkg::icc_t  icc;

	modport cu (
		output ir_en, pc_en, npc_en, mar_en, mdr_en, rf_we, psr_en,
		output alub_sel, ext_sel, pc_in_sel, mdr_sel, ra, rb, rd, alu_op,
		input  ir, icc
	);
	modport dp (
		input  ir_en, pc_en, npc_en, mar_en, mdr_en, rf_we, psr_en,
		input  alub_sel, ext_sel, pc_in_sel, mdr_sel, ra, rb, rd, alu_op,
		output ir, icc
	);
endinterface

// File: source/mem_if.sv
`timescale 1ns/100ps

interface mem_if;
	logic                ram_en; // Request strobe
	sparc_pkg::mem_op_e  ram_op;
	logic                mfc;    // Memory function complete
	sparc_pkg::word_t    addr;   // From MAR
	sparc_pkg::word_t    wdata;  // From MDR
	sparc_pkg::word_t    rdata;

	modport cu (output ram_en, ram_op, input mfc);
	modport dp (output addr, wdata, input rdata);
	modport ram (input ram_en, ram_op, addr, wdata, output mfc, rdata);
endinterface

// File: source/alu.sv
`timescale 1ns/100ps

module alu (
	input  sparc_pkg::word_t   a,
	input  sparc_pkg::word_t   b,
	input  sparc_pkg::alu_op_e op,
	output sparc_pkg::word_t   result,
	output sparc_pkg::icc_t    flags
);

	logic [32:0] sum;  // Bit 32 is carry out
	logic [32:0] diff; // Bit 32 is borrow

	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb begin
		flags.v = 1'b0; // Logic ops clear v and c
		flags.c = 1'b0;
		case (op)
			sparc_pkg::alu_and, sparc_pkg::alu_andcc: result = a & b;
			sparc_pkg::alu_or:  result = a | b;
			sparc_pkg::alu_xor: result = a ^ b;
			sparc_pkg::alu_sub, sparc_pkg::alu_subcc: begin
				result  = diff[31:0];
				flags.c = diff[32];
				flags.v = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			default: begin // add, addcc, jmpl and address math
				result  = sum[31:0];
				flags.c = sum[32];
				flags.v = (a[31] == b[31]) && (sum[31] != a[31]);
			end
		endcase
		flags.n = result[31];
		flags.z = (result == 32'd0);
	end

endmodule

// File: source/register_file.sv
`timescale 1ns/100ps

module register_file (
	input  logic                 Clk,
	input  logic                 RESET,
	input  logic                 we,
	input  sparc_pkg::reg_addr_t ra,
	input  sparc_pkg::reg_addr_t rb,
	input  sparc_pkg::reg_addr_t rd,
	input  sparc_pkg::reg_addr_t dbg_addr,
	input  sparc_pkg::word_t     wdata,
	output sparc_pkg::word_t     a,
	output sparc_pkg::word_t     b,
	output sparc_pkg::word_t     dbg_data
);

	sparc_pkg::word_t regs [32];

	always_ff @(posedge Clk) begin
		if (RESET) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd != 5'd0) begin // r0 writes dropped
			regs[rd] <= wdata;
		end
	end

	// r0 hardwired to zero on every read port
	assign a        = (ra == 5'd0) ? '0 : regs[ra];
	assign b        = (rb == 5'd0) ? '0 : regs[rb];
	assign dbg_data = (dbg_addr == 5'd0) ? '0 : regs[dbg_addr];

endmodule

// File: source/data_ram.sv
`timescale 1ns/100ps

module data_ram #(
	parameter int RAM_LATENCY = 2,
	parameter int RAM_WORDS   = 256
) (
	input logic Clk,
	input logic RESET,
	mem_if.ram  m
);

	localparam int ADDR_W = $clog2(RAM_WORDS * 4); // Byte address bits
	localparam int CNT_W  = $clog2(RAM_LATENCY + 1);

	logic [7:0]        mem [RAM_WORDS * 4];
	logic [ADDR_W-3:0] word_idx; // Word of the pending request
	logic [CNT_W-1:0]  cnt;      // Cycles left to mfc

	// Latency counter, mfc on its last cycle
	always_ff @(posedge Clk) begin
		if (RESET)
			cnt <= '0;
		else if (m.ram_en)
			cnt <= CNT_W'(RAM_LATENCY);
		else if (cnt != '0)
			cnt <= cnt - 1'b1;
	end

	assign m.mfc = (cnt == CNT_W'(1));

	// Writes land at the request edge, well ahead of mfc
	always_ff @(posedge Clk) begin
		if (m.ram_en) begin
			word_idx <= m.addr[ADDR_W-1:2];
			case (m.ram_op)
				sparc_pkg::mem_st:
					for (int i = 0; i < 4; i++)
						mem[{m.addr[ADDR_W-1:2], 2'(i)}] <= m.wdata[8*i +: 8];
				sparc_pkg::mem_stb: mem[m.addr[ADDR_W-1:0]] <= m.wdata[7:0]; // Single byte
				default: ; // Loads read below
			endcase
		end
	end

	// Whole word back for ld and ldub, byte 0 in the low bits
	assign m.rdata = {mem[{word_idx, 2'd3}], mem[{word_idx, 2'd2}],
		mem[{word_idx, 2'd1}], mem[{word_idx, 2'd0}]};

endmodule

// File: source/datapath.sv
`timescale 1ns/100ps

module datapath (
	input  logic                 Clk,
	input  logic                 RESET,
	input  sparc_pkg::word_t     instr,
	input  sparc_pkg::reg_addr_t dbg_addr,
	output sparc_pkg::word_t     pc,
	output sparc_pkg::word_t     npc,
	output sparc_pkg::word_t     dbg_data,
	ctrl_if.dp                   c,
	mem_if.dp                    m
);

	sparc_pkg::word_t ir, mar, mdr;
	sparc_pkg::icc_t  psr;
	sparc_pkg::icc_t  alu_flags;
	sparc_pkg::word_t rf_a, rf_b;
	sparc_pkg::word_t ext_out;
	sparc_pkg::word_t alu_b, alu_result;
	sparc_pkg::word_t mdr_val; // MDR as seen by the ALU
	sparc_pkg::word_t npc_in;
	logic [7:0] mdr_byte;
	logic       is_ldub;

	assign c.ir    = ir;
	assign c.icc   = psr;
	assign m.addr  = mar;
	assign m.wdata = mdr;

	// Sign extender
	always_comb begin
		case (c.ext_sel)
			sparc_pkg::ext_disp22: ext_out = {{8{ir[21]}}, ir[21:0], 2'b00}; // Word displacement
			default:               ext_out = {{19{ir[12]}}, ir[12:0]};
		endcase
	end

	// ldub picks its byte with the address bits still held in MAR, little endian
	assign mdr_byte = mdr[{mar[1:0], 3'b000} +: 8];
	assign is_ldub  = (ir[31:30] == sparc_pkg::fam_mem) && (ir[24:19] == sparc_pkg::mem_ldub);
	assign mdr_val  = is_ldub ? {24'h000000, mdr_byte} : mdr;

	always_comb begin
		case (c.alub_sel)
			sparc_pkg::alub_ext: alu_b = ext_out;
			sparc_pkg::alub_mdr: alu_b = mdr_val;
			sparc_pkg::alub_pc:  alu_b = pc;
			default:             alu_b = rf_b;
		endcase
	end

	always_comb begin
		case (c.pc_in_sel)
			sparc_pkg::pc_in_target: npc_in = pc + ext_out;  // Delayed branch target
			sparc_pkg::pc_in_alu:    npc_in = alu_result;    // JMPL
			default:                 npc_in = npc + 32'd4;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (RESET) begin
			pc  <= 32'd0;
			npc <= 32'd4;
			psr <= '0;
		end else begin
			if (c.pc_en)
				pc <= npc; // PC always follows old nPC
			if (c.npc_en)
				npc <= npc_in;
			if (c.psr_en)
				psr <= alu_flags;
		end
	end

	always_ff @(posedge Clk) begin
		if (c.ir_en)
			ir <= instr;
		if (c.mar_en)
			mar <= alu_result;
		if (c.mdr_en)
			mdr <= c.mdr_sel ? m.rdata : rf_b;
	end

	register_file u_rf (
		.Clk      (Clk),
		.RESET    (RESET),
		.we       (c.rf_we),
		.ra       (c.ra),
		.rb       (c.rb),
		.rd       (c.rd),
		.dbg_addr (dbg_addr),
		.wdata    (alu_result),
		.a        (rf_a),
		.b        (rf_b),
		.dbg_data (dbg_data)
	);

	alu u_alu (
		.a      (rf_a),
		.b      (alu_b),
		.op     (c.alu_op),
		.result (alu_result),
		.flags  (alu_flags)
	);

endmodule

// File: source/control_unit.sv
`timescale 1ns/100ps

module control_unit (
	input  logic Clk,
	input  logic RESET,
	input  logic instr_valid,
	output logic busy,
	ctrl_if.cu   c,
	mem_if.cu    m
);

	sparc_pkg::cu_state_e  state, next_state;
	sparc_pkg::op_family_e family;
	sparc_pkg::cond_e      cond;
	logic [5:0] op3;
	logic imm;      // i bit, simm13 operand
	logic is_bicc;
	logic taken;
	logic arith_ok; // op3 inside the supported arith subset
	logic is_jmpl;
	logic is_load;
	logic is_store;

	assign family  = sparc_pkg::op_family_e'(c.ir[31:30]);
	assign cond    = sparc_pkg::cond_e'(c.ir[28:25]);
	assign op3     = c.ir[24:19];
	assign imm     = c.ir[13];
	assign is_bicc = (family == sparc_pkg::fam_branch) && (c.ir[24:22] == sparc_pkg::bicc_op2);
	assign is_jmpl = (op3 == sparc_pkg::alu_jmpl);
	assign busy    = (state != sparc_pkg::s_idle);

	assign m.ram_op = sparc_pkg::mem_op_e'(op3); // RAM only looks at it on ram_en

	// Condition test on the current PSR flags
	always_comb begin
		case (cond)
			sparc_pkg::cond_ba:  taken = 1'b1;
			sparc_pkg::cond_bn:  taken = 1'b0;
			sparc_pkg::cond_be:  taken = c.icc.z;
			sparc_pkg::cond_bne: taken = !c.icc.z;
			sparc_pkg::cond_bl:  taken = c.icc.n ^ c.icc.v;
			sparc_pkg::cond_bge: taken = !(c.icc.n ^ c.icc.v);
			default:             taken = 1'b0; // Other conds never branch here
		endcase
	end

	// op3 decode
	always_comb begin
		case (sparc_pkg::alu_op_e'(op3))
			sparc_pkg::alu_add, sparc_pkg::alu_and, sparc_pkg::alu_or, sparc_pkg::alu_xor,
			sparc_pkg::alu_sub, sparc_pkg::alu_addcc, sparc_pkg::alu_andcc,
			sparc_pkg::alu_subcc: arith_ok = 1'b1;
			default:              arith_ok = 1'b0;
		endcase
		is_load  = 1'b0;
		is_store = 1'b0;
		case (sparc_pkg::mem_op_e'(op3))
			sparc_pkg::mem_ld, sparc_pkg::mem_ldub: is_load = 1'b1;
			sparc_pkg::mem_st, sparc_pkg::mem_stb:  is_store = 1'b1;
			default: ; // ldd, std, swap fall through as no-ops
		endcase
	end

	always_ff @(posedge Clk) begin
		if (RESET)
			state <= sparc_pkg::s_idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			sparc_pkg::s_idle:
				if (instr_valid)
					next_state = sparc_pkg::s_decode; // Only acceptance point
			sparc_pkg::s_decode:
				case (family)
					sparc_pkg::fam_arith:
						if (is_jmpl)
							next_state = sparc_pkg::s_jmpl_link;
						else if (arith_ok)
							next_state = sparc_pkg::s_alu_exec;
						else
							next_state = sparc_pkg::s_br_exec; // Unknown op3, PC advance only
					sparc_pkg::fam_mem:
						next_state = (is_load || is_store) ? sparc_pkg::s_mem_addr
							: sparc_pkg::s_br_exec;
					default:
						next_state = sparc_pkg::s_br_exec; // Branch, call
				endcase
			sparc_pkg::s_alu_exec:    next_state = sparc_pkg::s_alu_wb;
			sparc_pkg::s_jmpl_link:   next_state = sparc_pkg::s_jmpl_target;
			sparc_pkg::s_mem_addr:
				next_state = is_store ? sparc_pkg::s_st_mdr : sparc_pkg::s_mem_mar;
			sparc_pkg::s_st_mdr:      next_state = sparc_pkg::s_mem_mar;
			sparc_pkg::s_mem_mar:
				next_state = is_store ? sparc_pkg::s_st_wait : sparc_pkg::s_ld_wait;
			sparc_pkg::s_ld_wait:
				if (m.mfc)
					next_state = sparc_pkg::s_ld_mdr;
			sparc_pkg::s_ld_mdr:      next_state = sparc_pkg::s_ld_wb;
			sparc_pkg::s_st_wait:
				if (m.mfc)
					next_state = sparc_pkg::s_idle;
			default:                  next_state = sparc_pkg::s_idle; // alu_wb, br_exec etc
		endcase
	end

	// Outputs, operand routing defaults to rs1 and op2
	always_comb begin
		c.ir_en     = 1'b0;
		c.pc_en     = 1'b0;
		c.npc_en    = 1'b0;
		c.mar_en    = 1'b0;
		c.mdr_en    = 1'b0;
		c.rf_we     = 1'b0;
		c.psr_en    = 1'b0;
		m.ram_en    = 1'b0;
		c.ra        = c.ir[18:14];
		c.rb        = c.ir[4:0];
		c.rd        = c.ir[29:25];
		c.alub_sel  = imm ? sparc_pkg::alub_ext : sparc_pkg::alub_regb;
		c.ext_sel   = sparc_pkg::ext_simm13;
		c.pc_in_sel = sparc_pkg::pc_in_seq;
		c.mdr_sel   = 1'b1;
		c.alu_op    = sparc_pkg::alu_add;
		case (state)
			sparc_pkg::s_idle: c.ir_en = instr_valid;
			sparc_pkg::s_alu_exec: c.alu_op = sparc_pkg::alu_op_e'(op3); // Result settles
			sparc_pkg::s_alu_wb: begin
				c.alu_op = sparc_pkg::alu_op_e'(op3);
				c.rf_we  = 1'b1;
				c.psr_en = op3[4]; // cc forms only
				c.pc_en  = 1'b1;
				c.npc_en = 1'b1;
			end
			sparc_pkg::s_br_exec: begin
				c.ext_sel   = sparc_pkg::ext_disp22;
				c.pc_in_sel = (is_bicc && taken) ? sparc_pkg::pc_in_target : sparc_pkg::pc_in_seq;
				c.pc_en     = 1'b1;
				c.npc_en    = 1'b1;
			end
			sparc_pkg::s_jmpl_link: begin
				c.ra       = '0;                 // r0 + PC
				c.alub_sel = sparc_pkg::alub_pc;
				c.rf_we    = 1'b1;
			end
			sparc_pkg::s_jmpl_target: begin
				c.pc_in_sel = sparc_pkg::pc_in_alu; // nPC = rs1 + op2
				c.pc_en     = 1'b1;
				c.npc_en    = 1'b1;
			end
			sparc_pkg::s_mem_addr: c.mar_en = 1'b1; // Effective address into MAR
			sparc_pkg::s_st_mdr: begin
				c.rb      = c.ir[29:25]; // Store data from rd
				c.mdr_sel = 1'b0;
				c.mdr_en  = 1'b1;
			end
			sparc_pkg::s_mem_mar: m.ram_en = 1'b1;
			sparc_pkg::s_ld_wait: c.mdr_en = m.mfc; // rdata only valid with mfc
			sparc_pkg::s_ld_mdr: begin
				c.ra       = '0;
				c.alub_sel = sparc_pkg::alub_mdr;
			end
			sparc_pkg::s_ld_wb: begin
				c.ra       = '0;
				c.alub_sel = sparc_pkg::alub_mdr;
				c.rf_we    = 1'b1;
				c.pc_en    = 1'b1;
				c.npc_en   = 1'b1;
			end
			sparc_pkg::s_st_wait: begin
				c.pc_en  = m.mfc;
				c.npc_en = m.mfc;
			end
			default: ;
		endcase
	end

endmodule

// File: source/cpu_top.sv
`timescale 1ns/100ps

module cpu_top #(
	parameter int RAM_LATENCY = 2,
	parameter int RAM_WORDS   = 256
) (
	input  logic                 Clk,
	input  logic                 RESET,
	input  logic                 instr_valid,
	input  sparc_pkg::word_t     instr,
	input  sparc_pkg::reg_addr_t dbg_addr,
	output logic                 busy,
	output sparc_pkg::word_t     pc,
	output sparc_pkg::word_t     npc,
	output sparc_pkg::icc_t      icc,
	output sparc_pkg::word_t     dbg_data
);

	ctrl_if c_bus ();
	mem_if  m_bus ();

	assign icc = c_bus.icc; // PSR flags straight out

	control_unit u_cu (
		.Clk         (Clk),
		.RESET       (RESET),
		.instr_valid (instr_valid),
		.busy        (busy),
		.c           (c_bus.cu),
		.m           (m_bus.cu)
	);

	datapath u_dp (
		.Clk      (Clk),
		.RESET    (RESET),
		.instr    (instr),
		.dbg_addr (dbg_addr),
		.pc       (pc),
		.npc      (npc),
		.dbg_data (dbg_data),
		.c        (c_bus.dp),
		.m        (m_bus.dp)
	);

	data_ram #(
		.RAM_LATENCY (RAM_LATENCY),
		.RAM_WORDS   (RAM_WORDS)
	) u_ram (
		.Clk   (Clk),
		.RESET (RESET),
		.m     (m_bus.ram)
	);

endmodule

// File: test/cpu_assert.sv
`timescale 1ns/100ps

module cpu_assert (
	input logic                 Clk,
	input logic                 RESET,
	input logic                 busy,
	input logic                 mfc,
	input sparc_pkg::cu_state_e state,
	input logic                 ir_en,
	input logic                 pc_en,
	input logic                 npc_en,
	input logic                 mar_en,
	input logic                 mdr_en,
	input logic                 rf_we,
	input logic                 psr_en,
	input logic                 ram_en
);

	logic any_en;

	assign any_en = ir_en | pc_en | npc_en | mar_en | mdr_en | rf_we | psr_en | ram_en;

	// Quiet FSM right out of reset
	assert property (@(posedge Clk) RESET |=> (!busy && !any_en))
		else $error("busy or an enable high in the cycle after reset");

	assert property (@(posedge Clk) disable iff (RESET) !(rf_we && mar_en))
		else $error("rf_we and mar_en high together");

	assert property (@(posedge Clk) disable iff (RESET) ir_en |-> !busy)
		else $error("IR load while busy");

	// Load wait holds until the RAM answers
	assert property (@(posedge Clk) disable iff (RESET)
		(state == sparc_pkg::s_ld_wait && !mfc) |=> (state == sparc_pkg::s_ld_wait))
		else $error("ld_wait left without mfc");

endmodule

bind control_unit cpu_assert u_assert (
	.Clk    (Clk),
	.RESET  (RESET),
	.busy   (busy),
	.mfc    (m.mfc),
	.state  (state),
	.ir_en  (c.ir_en),
	.pc_en  (c.pc_en),
	.npc_en (c.npc_en),
	.mar_en (c.mar_en),
	.mdr_en (c.mdr_en),
	.rf_we  (c.rf_we),
	.psr_en (c.psr_en),
	.ram_en (m.ram_en)
);

// File: test/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

	localparam int RAM_LATENCY = 2;
	localparam int MAX_GAP     = 3; // Two LFSR bits per idle gap
	localparam sparc_pkg::word_t POISON = 32'hBE1027FF; // or r31, r0, 0x7ff

	logic                 Clk;
	logic                 RESET;
	logic                 instr_valid;
	sparc_pkg::word_t     instr;
	sparc_pkg::reg_addr_t dbg_addr;
	logic                 busy;
	sparc_pkg::word_t     pc;
	sparc_pkg::word_t     npc;
	sparc_pkg::word_t     dbg_data;
	sparc_pkg::icc_t      icc;

	byte              pat_cmd [$]; // One entry per pattern record
	sparc_pkg::word_t pat_a [$];
	sparc_pkg::word_t pat_b [$];
	logic [15:0]      lfsr;
	int               cycles;
	int               cycle_limit;

	cpu_top #(
		.RAM_LATENCY (RAM_LATENCY)
	) u_dut (
		.Clk         (Clk),
		.RESET       (RESET),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dbg_addr    (dbg_addr),
		.busy        (busy),
		.pc          (pc),
		.npc         (npc),
		.icc         (icc),
		.dbg_data    (dbg_data)
	);

	always #4 Clk = ~Clk; // 8 ns period

	// Watchdog on the whole run
	always @(posedge Clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
			report_failure("run went past its cycle limit and the DUT looks stuck");
	end

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic stop_run();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic report_failure(input string what);
		$display("%0t ns: %s", $time, what);
		stop_run();
	endtask

	task automatic check_word(input string name, input sparc_pkg::word_t expected,
			input sparc_pkg::word_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_icc(input string name, input sparc_pkg::icc_t expected,
			input sparc_pkg::icc_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
			stop_run();
		end
	endtask

	// Register value through the debug port
	task automatic check_reg(input sparc_pkg::reg_addr_t r, input sparc_pkg::word_t expected);
		@(posedge Clk);
		dbg_addr <= r;
		@(negedge Clk); // dbg_data settled
		check_word($sformatf("r%0d", r), expected, dbg_data);
	endtask

	task automatic run_instr(input sparc_pkg::word_t word);
		int gap;
		int i;
		gap = 0;
		for (i = 0; i < 2; i++) begin
			lfsr = lfsr_step(lfsr);
			gap  = (gap << 1) | lfsr[0];
		end
		repeat (gap) @(posedge Clk);
		@(posedge Clk);
		instr       <= word;
		instr_valid <= 1'b1;
		@(posedge Clk);   // Acceptance edge
		instr <= POISON;  // Strobe held one more cycle while busy
		@(posedge Clk);
		instr_valid <= 1'b0;
		@(negedge Clk);
		if (!busy)
			report_failure("busy did not rise after the instruction strobe");
		while (busy)
			@(negedge Clk);
	endtask

	// Skips blank lines and lines starting with #
	task automatic read_patterns();
		int               fd;
		int               n;
		string            line;
		byte              cmd;
		sparc_pkg::word_t f1;
		sparc_pkg::word_t f2;
		fd = $fopen("test/cpu_patterns.txt", "r");
		if (fd == 0)
			report_failure("could not open test/cpu_patterns.txt");
		while ($fgets(line, fd) != 0) begin
			f1 = '0;
			f2 = '0;
			n  = $sscanf(line, "%c %h %h", cmd, f1, f2);
			if (n >= 2 && cmd != "#") begin
				pat_cmd.push_back(cmd);
				pat_a.push_back(f1);
				pat_b.push_back(f2);
			end
		end
		$fclose(fd);
	endtask

	initial begin
		int r;
		Clk         = 1'b0;
		RESET       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		dbg_addr    = '0;
		lfsr        = 16'd2468;
		cycles      = 0;
		read_patterns();
		cycle_limit = 100 + pat_cmd.size() * (RAM_LATENCY + 10) + 3 * MAX_GAP;
		repeat (8) @(posedge Clk);
		RESET <= 1'b0;
		@(negedge Clk);
		if (busy)
			report_failure("busy is high right after reset");
		for (r = 0; r < 32; r++)
			check_reg(sparc_pkg::reg_addr_t'(r), '0); // Whole file cleared
		foreach (pat_cmd[k]) begin
			case (pat_cmd[k])
				"I": run_instr(pat_a[k]);
				"R": check_reg(sparc_pkg::reg_addr_t'(pat_a[k]), pat_b[k]);
				"P": begin
					@(negedge Clk);
					check_word("pc", pat_a[k], pc);
					check_word("npc", pat_b[k], npc);
				end
				"F": begin
					@(negedge Clk);
					check_icc("icc", sparc_pkg::icc_t'(pat_a[k][3:0]), icc);
				end
				default: report_failure($sformatf("unknown pattern command %c", pat_cmd[k]));
			endcase
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: test/cpu_patterns.txt
# I instr | R reg value | P pc npc | F nzvc, all fields hex
# Text after the fields is ignored
P 00000000 00000004
I 82102123 # or r1, r0, 0x123
I 84007FFF # add r2, r1, -1
I 86208001 # sub r3, r2, r1
I 8818C001 # xor r4, r3, r1
I 8A0920FF # and r5, r4, 0xff
I 80004001 # add r0, r1, r1
R 1 00000123
R 2 00000122
R 3 FFFFFFFF
R 4 FFFFFEDC
R 5 000000DC
R 0 00000000
F 0
P 00000018 0000001C
I 8CA04001 # subcc r6, r1, r1
F 4
I 02800003 # be +3, taken
P 00000020 00000028
I 12800003 # bne +3, not taken
P 00000028 0000002C
I 8E80E001 # addcc r7, r3, 1
R 7 00000000
F 5
I 90A08001 # subcc r8, r2, r1
F 9
I 06BFFFFE # bl -2, taken
P 00000034 00000028
I 16800005 # bge +5, not taken
P 00000028 0000002C
I 92886100 # andcc r9, r1, 0x100
R 9 00000100
F 0
I 16800004 # bge +4, taken
P 00000030 0000003C
I 06800004 # bl +4, not taken
I 10800002 # ba +2
I 00800002 # bn +2
P 00000044 00000048
I 02800002 # be +2, not taken
I 12800002 # bne +2, taken
P 0000004C 00000050
I C8226000 # st r4, [r9]
I D4026000 # ld r10, [r9]
I C22A6001 # stb r1, [r9 + 1]
I D60A6001 # ldub r11, [r9 + 1]
I D8026000 # ld r12, [r9]
R A FFFFFEDC
R B 00000023
R C FFFF23DC
P 00000060 00000064
I 9BC26020 # jmpl r13, r9 + 0x20
P 00000064 00000120
I 9DC24001 # jmpl r14, r9 + r1
P 00000120 00000223
R D 00000060
R E 00000064
R 1F 00000000
F 0

// File: files.f
source/sparc_pkg.sv
source/ctrl_if.sv
source/mem_if.sv
source/alu.sv
source/register_file.sv
source/data_ram.sv
source/datapath.sv
source/control_unit.sv
source/cpu_top.sv
test/cpu_assert.sv
test/cpu_tb.sv

// File: Bender.yml
package:
  name: sparc_mc_core

sources:
  - source/sparc_pkg.sv
  - source/ctrl_if.sv
  - source/mem_if.sv
  - source/alu.sv
  - source/register_file.sv
  - source/data_ram.sv
  - source/datapath.sv
  - source/control_unit.sv
  - source/cpu_top.sv
  - target: test
    files:
      - test/cpu_assert.sv
      - test/cpu_tb.sv
